// File: Makefile
TOP = tb_bpu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f bpu.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bpu.f
bpu_pkg.sv
bpu_update_if.sv
branch_decode.sv
direction_predictor.sv
branch_target_buffer.sv
return_stack.sv
bpu_top.sv
bpu_checker.sv
tb_bpu.sv

// File: bpu_checker.sv
`timescale 1ns/1ps

module bpu_checker import bpu_pkg::*; (
    input logic clk,
    input logic rst,
    input logic [xlen-1:0] pc_i,
    input logic is_branch_i,
    input logic pred_taken_i,
    input logic [xlen-1:0] pred_pc_i,
    input provider_e provider_i,
    input logic [hist_len-1:0] history_i
);

    int fail_count = 0;

    taken_is_branch: assert property (@(posedge clk) disable iff (rst)
        pred_taken_i |-> is_branch_i)
        else begin
            fail_count++;
            $error("taken prediction for an instruction that is no branch");
        end

    // fall-through target whenever not taken
    not_taken_pc: assert property (@(posedge clk) disable iff (rst)
        !pred_taken_i |-> (pred_pc_i == pc_i + 32'd4))
        else begin
            fail_count++;
            $error("not-taken prediction with a next pc other than pc plus 4");
        end

    outputs_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({is_branch_i, pred_taken_i, pred_pc_i, provider_i, history_i}))
        else begin
            fail_count++;
            $error("prediction output unknown outside reset");
        end

endmodule

bind bpu_top bpu_checker u_checker (
    .clk(clk), .rst(rst), .pc_i(if_pc_i), .is_branch_i(is_branch_o),
    .pred_taken_i(pred_taken_o), .pred_pc_i(pred_pc_o),
    .provider_i(pred_provider_o), .history_i(history_o)
);

// File: bpu_patterns.txt
# P pc inst is_branch taken pred_pc provider (0 bimodal, 1 t0, 2 t1)
# U pc inst taken correct history provider target, S return_address
P 00010000 00000863 1 0 00010004 0
P 00010040 00000013 0 0 00010044 0
U 00010000 00000863 1 1 0000 0 00010200
U 00010000 00000863 1 1 0001 0 00010200
P 00010000 00000863 1 1 00010200 0
P 00010100 100000ef 1 1 00010200 0
U 00010100 100000ef 1 1 0003 0 00010300
P 00010100 100000ef 1 1 00010300 0
U 00010080 00000863 1 0 0007 0 00010400
P 00010080 00000863 1 1 00010400 2
S 00020004
P 00010800 00008067 1 1 00020004 0
S 00030008
P 00010800 00008067 1 1 00030008 0
U 00010800 00008067 1 1 000f 0 00030008
P 00010800 00008067 1 1 00020004 0
U 00010800 00008067 1 1 001f 0 00020004
P 00010800 00008067 1 0 00010804 0
U 00010000 00000863 0 1 003f 0 00000000
P 00010040 00000013 0 0 00010044 0

// File: bpu_pkg.sv
package bpu_pkg;

    localparam int xlen = 32;
    localparam int hist_len = 16;

    // bimodal table, indexed by pc[9:1]
    localparam int bim_entries = 512;
    localparam int bim_idx_w = 9;
    localparam int bim_idx_lsb = 1;

    // tagged tables T0 and T1
    localparam int tag_entries = 256;
    localparam int tag_idx_w = 8;
    localparam int tag_w = 10;
    localparam int partial_tag_w = 6; // top tag bits compared on lookup
    localparam int tag_pc_lsb = 8;    // tag hashed from pc[17:8]

    // branch target buffer
    localparam int btb_entries = 256;
    localparam int btb_idx_w = 8;
    localparam int btb_idx_lsb = 2;
    localparam int btb_tag_w = 22; // upper pc bits

    // return address stack
    localparam int ras_depth = 16;
    localparam int ras_ptr_w = 5; // reaches ras_depth

    typedef logic [1:0] counter_t; // msb set means taken

    localparam counter_t ctr_strong_nt = 2'b00;
    localparam counter_t ctr_weak_nt = 2'b01;
    localparam counter_t ctr_weak_t = 2'b10;
    localparam counter_t ctr_strong_t = 2'b11;

    // link registers for call and return detection
    localparam logic [4:0] reg_ra = 5'd1;
    localparam logic [4:0] reg_t0 = 5'd5;

    typedef enum logic [1:0] {prov_bimodal, prov_t0, prov_t1} provider_e;

    typedef enum logic [6:0] {
        op_branch = 7'b1100011,
        op_jal = 7'b1101111,
        op_jalr = 7'b1100111
    } opcode_e;

    typedef enum logic [2:0] {kind_none, kind_branch, kind_jal, kind_jalr, kind_ret} inst_kind_e;

endpackage

// File: bpu_top.sv
`timescale 1ns/1ps

module bpu_top import bpu_pkg::*; (
    input logic clk,
    input logic rst,
    input logic [xlen-1:0] if_pc_i,
    input logic [xlen-1:0] if_inst_i,
    input logic ex_valid_i,
    input logic ex_taken_i,
    input logic ex_correct_i,
    input logic [xlen-1:0] ex_pc_i,
    input logic [xlen-1:0] ex_inst_i,
    input logic [hist_len-1:0] ex_history_i,
    input provider_e ex_provider_i,
    input logic [xlen-1:0] ex_target_i,
    input logic id_push_valid_i,
    input logic [xlen-1:0] id_push_data_i,
    input logic stall_i,
    output logic is_branch_o,
    output logic pred_taken_o,
    output logic [xlen-1:0] pred_pc_o,
    output provider_e pred_provider_o,
    output logic [hist_len-1:0] history_o
);

    inst_kind_e if_kind, ex_kind;
    logic [xlen-1:0] if_branch_imm, if_jal_imm;
    logic dir_taken;
    logic btb_hit;
    logic [xlen-1:0] btb_target;
    logic ras_valid;
    logic [xlen-1:0] ras_top;
    logic ras_push, ras_pop;

    bpu_update_if upd_bus ();

    assign upd_bus.valid = ex_valid_i;
    assign upd_bus.taken = ex_taken_i;
    assign upd_bus.correct = ex_correct_i;
    assign upd_bus.pc = ex_pc_i;
    assign upd_bus.history = ex_history_i;
    assign upd_bus.provider = ex_provider_i;
    assign upd_bus.target = ex_target_i;

    branch_decode u_if_decode (
        .inst_i(if_inst_i), .kind_o(if_kind),
        .branch_imm_o(if_branch_imm), .jal_imm_o(if_jal_imm)
    );

    // only the kind matters at execute
    branch_decode u_ex_decode (
        .inst_i(ex_inst_i), .kind_o(ex_kind), .branch_imm_o(), .jal_imm_o()
    );

    direction_predictor u_dir (
        .clk(clk), .rst(rst), .pc_i(if_pc_i), .upd(upd_bus),
        .taken_o(dir_taken), .provider_o(pred_provider_o), .history_o(history_o)
    );

    branch_target_buffer u_btb (
        .clk(clk), .rst(rst), .pc_i(if_pc_i), .upd(upd_bus),
        .hit_o(btb_hit), .target_o(btb_target)
    );

    assign ras_push = id_push_valid_i && !stall_i; // call seen at decode
    assign ras_pop = ex_valid_i && ex_taken_i && (ex_kind == kind_ret) && !stall_i;

    return_stack u_ras (
        .clk(clk), .rst(rst), .push_i(ras_push), .push_data_i(id_push_data_i),
        .pop_i(ras_pop), .top_valid_o(ras_valid), .top_o(ras_top)
    );

    assign is_branch_o = (if_kind != kind_none);

    always_comb begin
        pred_taken_o = 1'b0;
        pred_pc_o = if_pc_i + 32'd4;
        case (if_kind)
            kind_ret: begin
                if (ras_valid) begin // empty stack falls through
                    pred_taken_o = 1'b1;
                    pred_pc_o = ras_top;
                end
            end
            kind_jal: begin
                pred_taken_o = 1'b1;
                pred_pc_o = btb_hit ? btb_target : if_pc_i + if_jal_imm;
            end
            kind_branch: begin
                if (dir_taken) begin
                    pred_taken_o = 1'b1;
                    pred_pc_o = btb_hit ? btb_target : if_pc_i + if_branch_imm;
                end
            end
            default: ; // plain jalr and non-branches
        endcase
    end

endmodule

// File: bpu_update_if.sv
`timescale 1ns/1ps

// execute-stage feedback, one strobe per cycle, never refused
interface bpu_update_if import bpu_pkg::*; ();

    logic valid;
    logic taken;   // resolved direction
    logic correct; // prediction matched the outcome
    logic [xlen-1:0] pc;
    logic [hist_len-1:0] history; // history seen at prediction time
    provider_e provider;          // table that gave the prediction
    logic [xlen-1:0] target;

    modport upd_sink (
        input valid,
        input taken,
        input correct,
        input pc,
        input history,
        input provider,
        input target
    );

endinterface

// File: branch_decode.sv
`timescale 1ns/1ps

module branch_decode import bpu_pkg::*; (
    input logic [xlen-1:0] inst_i,
    output inst_kind_e kind_o,
    output logic [xlen-1:0] branch_imm_o,
    output logic [xlen-1:0] jal_imm_o
);

    logic [4:0] rd;
    logic [4:0] rs1;
    logic is_ret;

    assign rd = inst_i[11:7];
    assign rs1 = inst_i[19:15];

    // jalr x0, 0(ra) or 0(t0)
    assign is_ret = (rd == 5'd0) && ((rs1 == reg_ra) || (rs1 == reg_t0)) &&
                    (inst_i[31:20] == 12'd0);

    always_comb begin
        case (inst_i[6:0])
            op_branch: kind_o = kind_branch;
            op_jal: kind_o = kind_jal;
            op_jalr: kind_o = is_ret ? kind_ret : kind_jalr;
            default: kind_o = kind_none;
        endcase
    end

    // B-type offset
    assign branch_imm_o = {{(xlen-12){inst_i[31]}}, inst_i[7], inst_i[30:25],
                           inst_i[11:8], 1'b0};

    // J-type offset
    assign jal_imm_o = {{(xlen-20){inst_i[31]}}, inst_i[19:12], inst_i[20],
                        inst_i[30:21], 1'b0};

endmodule

// File: branch_target_buffer.sv
`timescale 1ns/1ps

module branch_target_buffer import bpu_pkg::*; (
    input logic clk,
    input logic rst,
    input logic [xlen-1:0] pc_i,
    bpu_update_if.upd_sink upd,
    output logic hit_o,
    output logic [xlen-1:0] target_o
);

    logic [btb_tag_w-1:0] tag_mem [btb_entries];
    logic [xlen-1:0] target_mem [btb_entries];
    logic [btb_entries-1:0] valid_q;

    logic [btb_idx_w-1:0] rd_idx, wr_idx;
    logic wr_en;

    assign rd_idx = pc_i[btb_idx_lsb +: btb_idx_w];
    assign wr_idx = upd.pc[btb_idx_lsb +: btb_idx_w];
    assign wr_en = upd.valid && upd.taken; // only taken branches allocate

    assign hit_o = valid_q[rd_idx] && (tag_mem[rd_idx] == pc_i[xlen-1 -: btb_tag_w]);
    assign target_o = target_mem[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            valid_q <= '0;
        else if (wr_en)
            valid_q[wr_idx] <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_idx] <= upd.pc[xlen-1 -: btb_tag_w];
            target_mem[wr_idx] <= upd.target;
        end
    end

endmodule

// File: direction_predictor.sv
`timescale 1ns/1ps

module direction_predictor import bpu_pkg::*; (
    input logic clk,
    input logic rst,
    input logic [xlen-1:0] pc_i,
    bpu_update_if.upd_sink upd,
    output logic taken_o,
    output provider_e provider_o,
    output logic [hist_len-1:0] history_o
);

    counter_t bim_ctr [bim_entries];
    counter_t t0_ctr [tag_entries];
    counter_t t1_ctr [tag_entries];
    logic [tag_w-1:0] t0_tag [tag_entries];
    logic [tag_w-1:0] t1_tag [tag_entries];
    logic [hist_len-1:0] hist_q;

    logic [bim_idx_w-1:0] bim_idx, u_bim_idx;
    logic [tag_idx_w-1:0] t0_idx, t1_idx, u_t0_idx, u_t1_idx;
    logic [tag_w-1:0] t0_tag_c, t1_tag_c, u_t0_tag, u_t1_tag;
    logic t0_match, t1_match;

    // T0 hashes the low history, T1 the high history
    function automatic logic [tag_idx_w-1:0] t0_index(input logic [xlen-1:0] pc,
                                                       input logic [hist_len-1:0] h);
        return pc[tag_idx_w-1:0] ^ h[tag_idx_w-1:0];
    endfunction

    function automatic logic [tag_idx_w-1:0] t1_index(input logic [xlen-1:0] pc,
                                                       input logic [hist_len-1:0] h);
        return pc[tag_idx_w-1:0] ^ h[hist_len-1 -: tag_idx_w];
    endfunction

    function automatic logic [tag_w-1:0] t0_tag_hash(input logic [xlen-1:0] pc,
                                                     input logic [hist_len-1:0] h);
        return pc[tag_pc_lsb +: tag_w] ^ h[hist_len-1 -: tag_w];
    endfunction

    function automatic logic [tag_w-1:0] t1_tag_hash(input logic [xlen-1:0] pc,
                                                     input logic [hist_len-1:0] h);
        return pc[tag_pc_lsb +: tag_w] ^ {{(tag_w-tag_idx_w){1'b0}}, h[tag_idx_w-1:0]};
    endfunction

    function automatic counter_t sat_step(input counter_t c, input logic up);
        counter_t r;
        r = c;
        if (up && (c != ctr_strong_t))
            r = c + 1'b1;
        else if (!up && (c != ctr_strong_nt))
            r = c - 1'b1;
        return r;
    endfunction

    // lookup side
    assign bim_idx = pc_i[bim_idx_lsb +: bim_idx_w];
    assign t0_idx = t0_index(pc_i, hist_q);
    assign t1_idx = t1_index(pc_i, hist_q);
    assign t0_tag_c = t0_tag_hash(pc_i, hist_q);
    assign t1_tag_c = t1_tag_hash(pc_i, hist_q);

    assign t0_match = t0_tag[t0_idx][tag_w-1 -: partial_tag_w] == t0_tag_c[tag_w-1 -: partial_tag_w];
    assign t1_match = t1_tag[t1_idx][tag_w-1 -: partial_tag_w] == t1_tag_c[tag_w-1 -: partial_tag_w];

    always_comb begin
        if (t1_match) begin // longer history wins
            provider_o = prov_t1;
            taken_o = t1_ctr[t1_idx][1];
        end else if (t0_match) begin
            provider_o = prov_t0;
            taken_o = t0_ctr[t0_idx][1];
        end else begin
            provider_o = prov_bimodal;
            taken_o = bim_ctr[bim_idx][1];
        end
    end

    // update side, indices rebuilt from the feedback
    assign u_bim_idx = upd.pc[bim_idx_lsb +: bim_idx_w];
    assign u_t0_idx = t0_index(upd.pc, upd.history);
    assign u_t1_idx = t1_index(upd.pc, upd.history);
    assign u_t0_tag = t0_tag_hash(upd.pc, upd.history);
    assign u_t1_tag = t1_tag_hash(upd.pc, upd.history);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bim_entries; i++)
                bim_ctr[i] <= ctr_weak_nt;
            for (int i = 0; i < tag_entries; i++) begin
                t0_ctr[i] <= ctr_weak_nt;
                t1_ctr[i] <= ctr_weak_nt;
                t0_tag[i] <= '0;
                t1_tag[i] <= '0;
            end
            hist_q <= '0;
        end else if (upd.valid) begin
            bim_ctr[u_bim_idx] <= sat_step(bim_ctr[u_bim_idx], upd.taken);
            hist_q <= {hist_q[hist_len-2:0], upd.taken};
            if (upd.correct) begin
                case (upd.provider)
                    prov_t0: t0_ctr[u_t0_idx] <= sat_step(t0_ctr[u_t0_idx], upd.taken);
                    prov_t1: t1_ctr[u_t1_idx] <= sat_step(t1_ctr[u_t1_idx], upd.taken);
                    default: ;
                endcase
            end else begin
                case (upd.provider)
                    prov_t0: t0_ctr[u_t0_idx] <= upd.taken ? ctr_strong_t : ctr_strong_nt;
                    prov_t1: t1_ctr[u_t1_idx] <= upd.taken ? ctr_strong_t : ctr_strong_nt;
                    default: begin
                        // bimodal missed, allocate T1 first
                        if (t1_tag[u_t1_idx] != u_t1_tag) begin
                            t1_tag[u_t1_idx] <= u_t1_tag;
                            t1_ctr[u_t1_idx] <= upd.taken ? ctr_weak_t : ctr_weak_nt;
                        end else if (t0_tag[u_t0_idx] != u_t0_tag) begin
                            t0_tag[u_t0_idx] <= u_t0_tag;
                            t0_ctr[u_t0_idx] <= upd.taken ? ctr_weak_t : ctr_weak_nt;
                        end
                    end
                endcase
            end
        end
    end

    assign history_o = hist_q;

endmodule

// File: return_stack.sv
`timescale 1ns/1ps

module return_stack import bpu_pkg::*; (
    input logic clk,
    input logic rst,
    input logic push_i,
    input logic [xlen-1:0] push_data_i,
    input logic pop_i,
    output logic top_valid_o,
    output logic [xlen-1:0] top_o
);

    logic [xlen-1:0] stack_mem [ras_depth];
    logic [ras_ptr_w-1:0] sp_q; // next free slot
    logic [ras_ptr_w-1:0] sp_popped;
    logic [ras_ptr_w-2:0] top_idx;
    logic do_pop;
    logic do_push;

    // pop resolves first, a push in the same cycle reuses the freed slot
    assign do_pop = pop_i && (sp_q != '0);
    assign sp_popped = do_pop ? sp_q - 1'b1 : sp_q;
    assign do_push = push_i && (sp_popped != ras_ptr_w'(ras_depth)); // full drops push

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            sp_q <= '0;
        else
            sp_q <= sp_popped + ras_ptr_w'(do_push);
    end

    always_ff @(posedge clk) begin
        if (do_push)
            stack_mem[sp_popped[ras_ptr_w-2:0]] <= push_data_i;
    end

    // wraps to the last slot when the stack is full
    assign top_idx = sp_q[ras_ptr_w-2:0] - 1'b1;

    assign top_valid_o = (sp_q != '0);
    assign top_o = stack_mem[top_idx];

endmodule

// File: tb_bpu.sv
`timescale 1ns/1ps

module tb_bpu import bpu_pkg::*; ();

    localparam int max_lines = 256; // bound on the pattern file reader
    localparam int max_idle = 3;
    localparam int max_wait = 16;

    typedef enum {cmd_none, cmd_predict, cmd_update, cmd_push} cmd_e;

    logic clk, rst;
    logic [xlen-1:0] if_pc, if_inst, ex_pc, ex_inst, ex_target, push_data;
    logic ex_valid, ex_taken, ex_correct, push_valid, stall;
    logic [hist_len-1:0] ex_history;
    provider_e ex_provider;
    logic is_branch, pred_taken;
    logic [xlen-1:0] pred_pc;
    provider_e pred_provider;
    logic [hist_len-1:0] history;

    int fd, code, errors, checks, line_no;
    bit aborted;
    string line;
    logic [hist_len-1:0] exp_hist; // taken bits of every update so far
    logic [xlen-1:0] f_pc, f_inst, f_addr;
    logic [hist_len-1:0] f_hist;
    logic [1:0] f_prov;
    logic f_bit0, f_bit1;

    bpu_top UUT (
        .clk(clk), .rst(rst), .if_pc_i(if_pc), .if_inst_i(if_inst),
        .ex_valid_i(ex_valid), .ex_taken_i(ex_taken), .ex_correct_i(ex_correct),
        .ex_pc_i(ex_pc), .ex_inst_i(ex_inst), .ex_history_i(ex_history),
        .ex_provider_i(ex_provider), .ex_target_i(ex_target),
        .id_push_valid_i(push_valid), .id_push_data_i(push_data), .stall_i(stall),
        .is_branch_o(is_branch), .pred_taken_o(pred_taken), .pred_pc_o(pred_pc),
        .pred_provider_o(pred_provider), .history_o(history)
    );

    always #50 clk = ~clk;

    function automatic cmd_e parse_cmd(input string s);
        if (s.len() == 0)
            return cmd_none;
        case (s.getc(0))
            "P": return cmd_predict;
            "U": return cmd_update;
            "S": return cmd_push;
            default: return cmd_none; // comments and blank lines
        endcase
    endfunction

    task automatic check_value(input string what, input logic [xlen-1:0] got,
                               input logic [xlen-1:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at time %0t: pattern line %0d %s is %h, expected %h",
                     $time, line_no, what, got, exp);
        end
    endtask

    // rising edge, then the drive delay
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        int k;
        k = 0;
        while (k < n && k < max_wait) begin
            next_cycle();
            k++;
        end
    endtask

    task automatic report_bad_line();
        errors++;
        $display("pattern line %0d has the wrong number of fields", line_no);
    endtask

    task automatic run_line(input string s);
        int n;
        case (parse_cmd(s))
            cmd_predict: begin
                n = $sscanf(s, "P %h %h %h %h %h %h", f_pc, f_inst, f_bit0, f_bit1,
                            f_addr, f_prov);
                if (n == 6) begin
                    if_pc = f_pc;
                    if_inst = f_inst;
                    #49; // outputs settled, next edge still ahead
                    check_value("is_branch", xlen'(is_branch), xlen'(f_bit0));
                    check_value("pred_taken", xlen'(pred_taken), xlen'(f_bit1));
                    check_value("pred_pc", pred_pc, f_addr);
                    check_value("provider", xlen'(pred_provider), xlen'(f_prov));
                    check_value("history", xlen'(history), xlen'(exp_hist));
                    next_cycle();
                end else
                    report_bad_line();
            end
            cmd_update: begin
                n = $sscanf(s, "U %h %h %h %h %h %h %h", f_pc, f_inst, f_bit0, f_bit1,
                            f_hist, f_prov, f_addr);
                if (n == 7) begin
                    ex_pc = f_pc;
                    ex_inst = f_inst;
                    ex_taken = f_bit0;
                    ex_correct = f_bit1;
                    ex_history = f_hist;
                    ex_provider = provider_e'(f_prov);
                    ex_target = f_addr;
                    ex_valid = 1'b1;
                    next_cycle();
                    ex_valid = 1'b0;
                    exp_hist = {exp_hist[hist_len-2:0], f_bit0};
                end else
                    report_bad_line();
            end
            cmd_push: begin
                n = $sscanf(s, "S %h", f_addr);
                if (n == 1) begin
                    push_data = f_addr;
                    push_valid = 1'b1;
                    next_cycle();
                    push_valid = 1'b0;
                end else
                    report_bad_line();
            end
            default: ;
        endcase
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        if_pc = '0;
        if_inst = '0;
        ex_valid = 1'b0;
        ex_taken = 1'b0;
        ex_correct = 1'b0;
        ex_pc = '0;
        ex_inst = '0;
        ex_history = '0;
        ex_provider = prov_bimodal;
        ex_target = '0;
        push_valid = 1'b0;
        push_data = '0;
        stall = 1'b0;
        errors = 0;
        checks = 0;
        line_no = 0;
        aborted = 1'b0;
        exp_hist = '0;
        void'($urandom(32'h7ee8_3c09));

        idle_cycles(3); // reset over three edges
        rst = 1'b0;

        fd = $fopen("bpu_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open bpu_patterns.txt");
        end else begin
            while (!$feof(fd) && !aborted) begin
                code = $fgets(line, fd);
                line_no++;
                if (line_no > max_lines) begin
                    aborted = 1'b1;
                    errors++;
                    $display("pattern file still not at its end after %0d lines", max_lines);
                end else if (code != 0) begin
                    run_line(line);
                    idle_cycles($urandom_range(max_idle, 0));
                end
            end
            $fclose(fd);
        end

        errors += UUT.u_checker.fail_count; // bound assertion failures
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule
